// ==== Makefile ====
# Verilator flow for the RGBW LED color engine
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_rgbw_led_controller
RTL_TOP   ?= rgbw_led_controller
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
LINT_OPTS ?= --lint-only --timing --assert
SIM_OPTS  ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_OPTS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
led_color_pkg.sv
led_ctrl_pkg.sv
mult_if.sv
seq_multiplier.sv
color_wheel_processor.sv
rgbw_pwm.sv
rgbw_led_controller.sv
tb_rgbw_led_controller.sv

// ==== color_wheel_processor.sv ====
// color engine state machine: direct copy, or hue wheel plus tint and intensity via mult_if
`timescale 1ns/1ps

module color_wheel_processor
(
    input  logic                  clk,
    input  logic                  reset,
    input  led_ctrl_pkg::mode_t   mode,
    input  led_color_pkg::color_t lint,
    input  led_color_pkg::hue_t   color_idx,
    input  led_color_pkg::color_t white_in,
    input  led_color_pkg::color_t red_in,
    input  led_color_pkg::color_t green_in,
    input  led_color_pkg::color_t blue_in,
    mult_if.requester             mr,
    output led_color_pkg::color_t red_out,
    output led_color_pkg::color_t green_out,
    output led_color_pkg::color_t blue_out,
    output led_color_pkg::color_t white_out
);

    import led_color_pkg::*;
    import led_ctrl_pkg::*;

    wheel_state_t state;
    wheel_state_t same_step;  // step state of the segment being checked
    wheel_state_t next_seg;   // where the walk goes once the segment is done
    hue_t         seg_end;
    hue_t         counter;    // wheel position reached so far
    hue_t         thr;        // target hue of this pass
    color_t       lint_q;
    color_t       white_q;
    color_t       hue_r;
    color_t       hue_g;
    color_t       hue_b;
    color_t       w_scaled;
    color_t       r_scaled;
    color_t       g_scaled;
    color_t       b_scaled;
    logic         scaling;
    logic         take;       // product ready for the current request
    logic         raise;      // multiplier idle, ok to assert ld

    // saturating add, used for the wheel steps and for the tint
    function automatic color_t sat_add(color_t x, color_t y);
        logic [8:0] sum;
        sum = {1'b0, x} + {1'b0, y};
        return sum[8] ? 8'hff : sum[7:0];
    endfunction

    function automatic color_t sat_sub(color_t x, color_t y);
        return (x < y) ? 8'h00 : x - y;
    endfunction

    always_comb
    begin
        seg_end   = SEG_END_6;
        same_step = WS_IDLE;
        next_seg  = WS_IDLE;
        case (state)
            WS_CHECK1: begin seg_end = SEG_END_1; same_step = WS_STEP1; next_seg = WS_STEP2; end
            WS_CHECK2: begin seg_end = SEG_END_2; same_step = WS_STEP2; next_seg = WS_STEP3; end
            WS_CHECK3: begin seg_end = SEG_END_3; same_step = WS_STEP3; next_seg = WS_STEP4; end
            WS_CHECK4: begin seg_end = SEG_END_4; same_step = WS_STEP4; next_seg = WS_STEP5; end
            WS_CHECK5: begin seg_end = SEG_END_5; same_step = WS_STEP5; next_seg = WS_STEP6; end
            WS_CHECK6:
            begin
                seg_end   = SEG_END_6;
                same_step = WS_STEP6;
                next_seg  = WS_WHITE_SAT;  // table exhausted
            end
            default: ;
        endcase
    end

    assign scaling = state inside {WS_SCALE_W, WS_SCALE_R, WS_SCALE_G, WS_SCALE_B};
    assign take    = scaling && mr.ok && mr.ld;
    assign raise   = scaling && !mr.ok && !mr.ld;

    // intensity is always one operand, the channel is picked by the scaling state
    assign mr.a = lint_q;
    always_comb
    begin
        case (state)
            WS_SCALE_R: mr.b = hue_r;
            WS_SCALE_G: mr.b = hue_g;
            WS_SCALE_B: mr.b = hue_b;
            default:    mr.b = white_q;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state     <= WS_IDLE;
            counter   <= '0;
            mr.ld     <= 1'b0;
            red_out   <= '0;
            green_out <= '0;
            blue_out  <= '0;
            white_out <= '0;
        end
        else
        begin
            if (take)
                mr.ld <= 1'b0;
            else if (raise)
                mr.ld <= 1'b1;

            case (state)
                WS_IDLE:
                begin
                    counter <= 8'd1;
                    if (mode == MODE_DIRECT)
                    begin
                        red_out   <= red_in;
                        green_out <= green_in;
                        blue_out  <= blue_in;
                        white_out <= white_in;
                    end
                    else if (mode == MODE_WHEEL)
                        state <= WS_STEP1;
                end
                WS_STEP1: state <= WS_CHECK1;
                WS_STEP2: state <= WS_CHECK2;
                WS_STEP3: state <= WS_CHECK3;
                WS_STEP4:
                begin
                    counter <= counter + 8'd1;  // this segment counts in its step state
                    state   <= WS_CHECK4;
                end
                WS_STEP5: state <= WS_CHECK5;
                WS_STEP6: state <= WS_CHECK6;
                WS_CHECK1, WS_CHECK2, WS_CHECK3, WS_CHECK4, WS_CHECK5, WS_CHECK6:
                begin
                    if (counter < thr)
                    begin
                        if (state != WS_CHECK4)
                            counter <= counter + 8'd1;
                        state <= (counter < seg_end) ? same_step : next_seg;
                    end
                    else
                        state <= WS_WHITE_SAT;  // target hue reached
                end
                WS_WHITE_SAT: state <= WS_SCALE_W;
                WS_SCALE_W: if (take) state <= WS_SCALE_R;
                WS_SCALE_R: if (take) state <= WS_SCALE_G;
                WS_SCALE_G: if (take) state <= WS_SCALE_B;
                WS_SCALE_B: if (take) state <= WS_OUT;
                WS_OUT:
                begin
                    red_out   <= r_scaled;
                    green_out <= g_scaled;
                    blue_out  <= b_scaled;
                    white_out <= w_scaled;
                    state     <= WS_IDLE;
                end
                default: state <= WS_IDLE;
            endcase
        end
    end

    // hue and scaling datapath
    always_ff @(posedge clk)
    begin
        case (state)
            WS_IDLE:
            begin
                hue_r   <= '0;
                hue_g   <= '0;
                hue_b   <= '0;
                thr     <= color_idx;
                lint_q  <= lint;
                white_q <= white_in;
            end
            WS_STEP1: begin hue_r <= 8'hff; hue_g <= 8'h00; hue_b <= sat_add(hue_b, HUE_STEP); end
            WS_STEP2: begin hue_r <= sat_sub(hue_r, HUE_STEP); hue_g <= 8'h00; hue_b <= 8'hff; end
            WS_STEP3: begin hue_r <= 8'h00; hue_g <= sat_add(hue_g, HUE_STEP); hue_b <= 8'hff; end
            WS_STEP4: begin hue_r <= 8'h00; hue_g <= 8'hff; hue_b <= sat_sub(hue_b, HUE_STEP); end
            WS_STEP5: begin hue_r <= sat_add(hue_r, HUE_STEP); hue_g <= 8'hff; hue_b <= 8'h00; end
            WS_STEP6: begin hue_r <= 8'hff; hue_g <= sat_sub(hue_g, HUE_STEP); hue_b <= 8'h00; end
            WS_WHITE_SAT:
            begin
                hue_r <= sat_add(hue_r, white_q);  // tint
                hue_g <= sat_add(hue_g, white_q);
                hue_b <= sat_add(hue_b, white_q);
            end
            WS_SCALE_W: if (take) w_scaled <= mr.res[15:8];
            WS_SCALE_R: if (take) r_scaled <= mr.res[15:8];
            WS_SCALE_G: if (take) g_scaled <= mr.res[15:8];
            WS_SCALE_B: if (take) b_scaled <= mr.res[15:8];
            default: ;
        endcase
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!reset)
        state inside {[WS_IDLE:WS_OUT]});

    // a finished request must be released before the next pass starts
    a_no_ld_in_idle: assert property (@(posedge clk) disable iff (!reset)
        (state == WS_IDLE) |-> !mr.ld);

endmodule

// ==== led_color_pkg.sv ====
// color data types and hue-wheel constants, imported by the processor, multiplier and pwm
package led_color_pkg;

    typedef logic [7:0]  color_t;    // one color or intensity level
    typedef logic [15:0] product_t;  // full 8x8 multiplier product
    typedef logic [7:0]  hue_t;      // hue wheel position, 256 steps

    // a rising or falling primary moves this much per wheel step
    localparam color_t HUE_STEP = 8'd7;

    // counter value where each of the six hue segments hands over to the next
    localparam hue_t SEG_END_1 = 8'h2a;  // blue rising, red full
    localparam hue_t SEG_END_2 = 8'h54;  // red falling, blue full
    localparam hue_t SEG_END_3 = 8'h7e;  // green rising, blue full
    localparam hue_t SEG_END_4 = 8'ha8;  // blue falling, green full
    localparam hue_t SEG_END_5 = 8'hd2;  // red rising, green full
    localparam hue_t SEG_END_6 = 8'hfc;  // green falling, red full

endpackage

// ==== led_ctrl_pkg.sv ====
// mode codes and state machine encodings, imported by the processor and the multiplier
package led_ctrl_pkg;

    typedef logic [7:0] mode_t;

    localparam mode_t MODE_DIRECT = 8'h21;  // copy direct color inputs
    localparam mode_t MODE_WHEEL  = 8'ha4;  // hue wheel, tint and intensity

    // processor states, one step/check pair per hue segment
    typedef enum logic [4:0] {
        WS_IDLE,
        WS_STEP1, WS_CHECK1,
        WS_STEP2, WS_CHECK2,
        WS_STEP3, WS_CHECK3,
        WS_STEP4, WS_CHECK4,
        WS_STEP5, WS_CHECK5,
        WS_STEP6, WS_CHECK6,
        WS_WHITE_SAT,
        WS_SCALE_W, WS_SCALE_R, WS_SCALE_G, WS_SCALE_B,
        WS_OUT
    } wheel_state_t;

    typedef enum logic [1:0] {MS_IDLE, MS_BUSY, MS_DONE} mult_state_t;

endpackage

// ==== mult_if.sv ====
// load/done handshake between the color processor and the sequential multiplier
`timescale 1ns/1ps

interface mult_if;
    import led_color_pkg::*;

    color_t   a;    // intensity operand
    color_t   b;    // channel operand
    logic     ld;   // load level, held until ok is seen
    logic     ok;   // product valid, held until ld drops
    product_t res;

    modport requester (
        output a,
        output b,
        output ld,
        input  ok,
        input  res
    );

    modport multiplier (
        input  a,
        input  b,
        input  ld,
        output ok,
        output res
    );

endinterface

// ==== rgbw_led_controller.sv ====
// top level of the rgbw led color engine, wiring the processor, multiplier and pwm
`timescale 1ns/1ps

module rgbw_led_controller
#(
    parameter int PWM_BITS = 8
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  led_ctrl_pkg::mode_t   mode,
    input  led_color_pkg::color_t lint,
    input  led_color_pkg::hue_t   color_idx,
    input  led_color_pkg::color_t white_in,
    input  led_color_pkg::color_t red_in,
    input  led_color_pkg::color_t green_in,
    input  led_color_pkg::color_t blue_in,
    output led_color_pkg::color_t red_level,
    output led_color_pkg::color_t green_level,
    output led_color_pkg::color_t blue_level,
    output led_color_pkg::color_t white_level,
    output logic                  red_pwm,
    output logic                  green_pwm,
    output logic                  blue_pwm,
    output logic                  white_pwm
);

    mult_if mb ();  // shared 8x8 multiplier link

    color_wheel_processor u_proc (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .lint      (lint),
        .color_idx (color_idx),
        .white_in  (white_in),
        .red_in    (red_in),
        .green_in  (green_in),
        .blue_in   (blue_in),
        .mr        (mb.requester),
        .red_out   (red_level),
        .green_out (green_level),
        .blue_out  (blue_level),
        .white_out (white_level)
    );

    seq_multiplier u_mult (
        .clk   (clk),
        .reset (reset),
        .mb    (mb.multiplier)
    );

    // levels drive the pins as well as the observation ports
    rgbw_pwm #(
        .PWM_BITS (PWM_BITS)
    ) u_pwm (
        .clk        (clk),
        .reset      (reset),
        .red_duty   (red_level),
        .green_duty (green_level),
        .blue_duty  (blue_level),
        .white_duty (white_level),
        .red_pwm    (red_pwm),
        .green_pwm  (green_pwm),
        .blue_pwm   (blue_pwm),
        .white_pwm  (white_pwm)
    );

endmodule

// ==== rgbw_pwm.sv ====
// four-channel pwm generator turning the rgbw color levels into led drive pins
`timescale 1ns/1ps

module rgbw_pwm
#(
    parameter int PWM_BITS = 8
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  led_color_pkg::color_t red_duty,
    input  led_color_pkg::color_t green_duty,
    input  led_color_pkg::color_t blue_duty,
    input  led_color_pkg::color_t white_duty,
    output logic                  red_pwm,
    output logic                  green_pwm,
    output logic                  blue_pwm,
    output logic                  white_pwm
);

    import led_color_pkg::*;

    logic [PWM_BITS-1:0] cnt;       // free-running period counter
    logic [PWM_BITS+7:0] cnt_ext;   // padded so any width gives an 8-bit top
    color_t              cnt_top;
    logic                wrap;
    color_t              duty_in [4];
    color_t              duty_q  [4];  // held for a whole period
    logic [3:0]          pin;

    assign wrap    = &cnt;
    assign cnt_ext = {cnt, 8'h00};
    assign cnt_top = cnt_ext[PWM_BITS+7 -: 8];

    assign duty_in[0] = red_duty;
    assign duty_in[1] = green_duty;
    assign duty_in[2] = blue_duty;
    assign duty_in[3] = white_duty;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            cnt <= '0;
            for (int i = 0; i < 4; i++)
                duty_q[i] <= '0;
        end
        else
        begin
            cnt <= cnt + 1'b1;
            if (wrap)  // new duties take effect from the next period
            begin
                for (int i = 0; i < 4; i++)
                    duty_q[i] <= duty_in[i];
            end
        end
    end

    for (genvar ch = 0; ch < 4; ch++)
    begin : g_chan
        assign pin[ch] = (cnt_top < duty_q[ch]);

        // a zero duty taken at the wrap keeps the pin low in the following period
        a_zero_duty_low: assert property (@(posedge clk) disable iff (!reset)
            (wrap && duty_in[ch] == 8'h00) |=> !pin[ch]);
    end

    assign red_pwm   = pin[0];
    assign green_pwm = pin[1];
    assign blue_pwm  = pin[2];
    assign white_pwm = pin[3];

endmodule

// ==== seq_multiplier.sv ====
// shift-and-add 8x8 unsigned multiplier, started by a rising ld on its mult_if port
`timescale 1ns/1ps

module seq_multiplier
(
    input  logic       clk,
    input  logic       reset,
    mult_if.multiplier mb
);

    import led_color_pkg::*;
    import led_ctrl_pkg::*;

    mult_state_t state;
    logic        ld_q;      // ld from the previous cycle, for edge detection
    logic        start;
    logic [2:0]  bit_cnt;   // add-shift cycles done
    product_t    acc;
    product_t    mcand;     // shifted left once per cycle
    color_t      mplier;    // consumed lsb first

    assign start  = (state == MS_IDLE) && mb.ld && !ld_q;
    assign mb.res = acc;    // stable once the state leaves busy

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state   <= MS_IDLE;
            ld_q    <= 1'b0;
            bit_cnt <= '0;
            mb.ok   <= 1'b0;
        end
        else
        begin
            ld_q <= mb.ld;
            case (state)
                MS_IDLE:
                begin
                    bit_cnt <= '0;
                    if (start)
                        state <= MS_BUSY;
                end
                MS_BUSY:
                begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7)
                        state <= MS_DONE;
                end
                MS_DONE:
                begin
                    mb.ok <= mb.ld;  // raised while ld holds, dropped once it falls
                    if (!mb.ld)
                        state <= MS_IDLE;
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            acc    <= '0;
            mcand  <= {8'h00, mb.a};
            mplier <= mb.b;
        end
        else if (state == MS_BUSY)
        begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // the requester must wait for ok to drop before loading again
    a_no_load_while_busy: assert property (@(posedge clk) disable iff (!reset)
        (state == MS_BUSY) |-> !$rose(mb.ld));

endmodule

// ==== tb_rgbw_led_controller.sv ====
// self-checking testbench for the rgbw led controller, compiled from build.f as the top module
`timescale 1ns/1ps

module tb_rgbw_led_controller;

    localparam int NUM_FIXED   = 24;
    localparam int NUM_RANDOM  = 8;
    localparam int TIMEOUT     = 2000;
    localparam int HOLD_CYCLES = 700;   // longer than the slowest wheel pass
    localparam logic [7:0] DIRECT = 8'h21;
    localparam logic [7:0] WHEEL  = 8'ha4;

    // each entry holds mode, lint, color_idx, white_in, red_in, green_in, blue_in
    localparam logic [55:0] STIM_TABLE [NUM_FIXED] = '{
        56'h21_00_00_44_11_22_33,  // direct copy
        56'h5a_ff_80_00_aa_bb_cc,  // unknown mode leaves the levels
        56'ha4_ff_00_00_00_00_00,  // pure hue at full intensity
        56'ha4_ff_15_00_12_34_56,
        56'ha4_ff_2a_00_00_00_00,
        56'ha4_ff_2b_00_00_00_00,
        56'ha4_ff_40_00_00_00_00,
        56'ha4_ff_54_00_00_00_00,
        56'ha4_ff_60_00_00_00_00,
        56'ha4_ff_7e_00_00_00_00,
        56'ha4_ff_90_00_00_00_00,
        56'ha4_ff_a8_00_00_00_00,
        56'ha4_ff_b0_00_00_00_00,
        56'ha4_ff_d2_00_00_00_00,
        56'ha4_ff_e0_00_00_00_00,
        56'ha4_ff_fc_00_00_00_00,
        56'ha4_80_ff_00_00_00_00,  // end of the boundary table at half intensity
        56'h00_12_34_56_78_9a_bc,  // unknown mode after a wheel pass
        56'ha4_ff_30_40_00_00_00,  // tint
        56'ha4_80_90_c0_00_00_00,
        56'ha4_00_60_ff_00_00_00,  // zero intensity
        56'ha4_ff_10_ff_00_00_00,
        56'ha4_c8_c8_e6_00_00_00,
        56'h21_00_00_ff_80_01_ff
    };

    logic        clk;
    logic        reset;
    logic [7:0]  mode;
    logic [7:0]  lint;
    logic [7:0]  color_idx;
    logic [7:0]  white_in;
    logic [7:0]  red_in;
    logic [7:0]  green_in;
    logic [7:0]  blue_in;
    logic [7:0]  red_level;
    logic [7:0]  green_level;
    logic [7:0]  blue_level;
    logic [7:0]  white_level;
    logic        red_pwm;
    logic        green_pwm;
    logic        blue_pwm;
    logic        white_pwm;
    logic [31:0] levels;
    int          errors;
    int          timeouts;
    int          seed;

    assign levels = {red_level, green_level, blue_level, white_level};

    rgbw_led_controller #(
        .PWM_BITS (8)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .mode        (mode),
        .lint        (lint),
        .color_idx   (color_idx),
        .white_in    (white_in),
        .red_in      (red_in),
        .green_in    (green_in),
        .blue_in     (blue_in),
        .red_level   (red_level),
        .green_level (green_level),
        .blue_level  (blue_level),
        .white_level (white_level),
        .red_pwm     (red_pwm),
        .green_pwm   (green_pwm),
        .blue_pwm    (blue_pwm),
        .white_pwm   (white_pwm)
    );

    always #50 clk = ~clk;

    function automatic logic [7:0] add_clip(input logic [7:0] x, input logic [7:0] y);
        logic [8:0] s;
        s = {1'b0, x} + {1'b0, y};
        return s[8] ? 8'hff : s[7:0];
    endfunction

    function automatic logic [7:0] sub_clip(input logic [7:0] x, input logic [7:0] y);
        return (x < y) ? 8'h00 : x - y;
    endfunction

    function automatic logic [7:0] upper_byte(input logic [7:0] x, input logic [7:0] y);
        logic [15:0] p;
        p = {8'h00, x} * {8'h00, y};
        return p[15:8];
    endfunction

    function automatic logic [7:0] segment_end(input int seg);
        case (seg)
            1: return 8'h2a;
            2: return 8'h54;
            3: return 8'h7e;
            4: return 8'ha8;
            5: return 8'hd2;
            default: return 8'hfc;
        endcase
    endfunction

    // reference wheel pass returning {red, green, blue, white}
    function automatic logic [31:0] wheel_levels(input logic [7:0] lvl, input logic [7:0] idx,
                                                 input logic [7:0] wht);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        int         seg;
        int         pos;
        int         at;
        logic       done;
        r = 8'h00;
        g = 8'h00;
        b = 8'h00;
        seg = 1;
        pos = 1;
        done = 1'b0;
        while (!done)
        begin
            case (seg)
                1: {r, g, b} = {8'hff, 8'h00, add_clip(b, 8'd7)};
                2: {r, g, b} = {sub_clip(r, 8'd7), 8'h00, 8'hff};
                3: {r, g, b} = {8'h00, add_clip(g, 8'd7), 8'hff};
                4: {r, g, b} = {8'h00, 8'hff, sub_clip(b, 8'd7)};
                5: {r, g, b} = {add_clip(r, 8'd7), 8'hff, 8'h00};
                default: {r, g, b} = {8'hff, sub_clip(g, 8'd7), 8'h00};
            endcase
            if (seg == 4)
                pos = pos + 1;  // fourth segment counts while stepping
            if (pos >= int'(idx))
                done = 1'b1;
            else
            begin
                at = pos;
                if (seg != 4)
                    pos = pos + 1;
                if (at >= int'(segment_end(seg)))
                begin
                    if (seg == 6)
                        done = 1'b1;  // boundary table used up
                    else
                        seg = seg + 1;
                end
            end
        end
        r = add_clip(r, wht);
        g = add_clip(g, wht);
        b = add_clip(b, wht);
        return {upper_byte(lvl, r), upper_byte(lvl, g), upper_byte(lvl, b), upper_byte(lvl, wht)};
    endfunction

    function automatic logic [31:0] expected_levels(input logic [55:0] e, input logic [31:0] prev);
        if (e[55:48] == DIRECT)
            return {e[23:16], e[15:8], e[7:0], e[31:24]};
        if (e[55:48] == WHEEL)
            return wheel_levels(e[47:40], e[39:32], e[31:24]);
        return prev;  // other codes keep the registers
    endfunction

    function automatic logic [55:0] random_entry();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [55:0] e;
        r0 = $random(seed);
        r1 = $random(seed);
        e = {r0, r1[23:0]};
        case (r1[31:30])
            2'd0: e[55:48] = DIRECT;
            2'd3: e[55:48] = 8'h5c;  // no such mode
            default: e[55:48] = WHEEL;
        endcase
        return e;
    endfunction

    task automatic compare(input string name, input logic [15:0] actual,
                           input logic [15:0] expected);
        if (actual !== expected)
        begin
            errors++;
            $display("Error: %s = %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_levels(input logic [31:0] exp);
        compare("red_level", 16'(red_level), 16'(exp[31:24]));
        compare("green_level", 16'(green_level), 16'(exp[23:16]));
        compare("blue_level", 16'(blue_level), 16'(exp[15:8]));
        compare("white_level", 16'(white_level), 16'(exp[7:0]));
    endtask

    task automatic apply_entry(input logic [55:0] e);
        @(posedge clk);
        mode      <= e[55:48];
        lint      <= e[47:40];
        color_idx <= e[39:32];
        white_in  <= e[31:24];
        red_in    <= e[23:16];
        green_in  <= e[15:8];
        blue_in   <= e[7:0];
    endtask

    task automatic wait_for_levels(input logic [31:0] exp);
        int n;
        n = 0;
        @(negedge clk);
        while (levels !== exp && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT)
        begin
            timeouts++;
            $display("timeout: level outputs did not reach the expected colors in %0d cycles",
                     TIMEOUT);
        end
    endtask

    // leaves early as soon as a level moves
    task automatic hold_levels(input logic [31:0] exp);
        int n;
        n = 0;
        @(negedge clk);
        while (levels === exp && n < HOLD_CYCLES)
        begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic measure_pwm(input logic [31:0] exp);
        int red_hi;
        int green_hi;
        int blue_hi;
        int white_hi;
        repeat (257) @(posedge clk);  // a wrap has latched the settled levels
        @(negedge clk);
        red_hi = 0;
        green_hi = 0;
        blue_hi = 0;
        white_hi = 0;
        for (int n = 0; n < 256; n++)
        begin
            red_hi   = red_hi + int'(red_pwm);
            green_hi = green_hi + int'(green_pwm);
            blue_hi  = blue_hi + int'(blue_pwm);
            white_hi = white_hi + int'(white_pwm);
            @(negedge clk);
        end
        compare("red_pwm high cycles", 16'(red_hi), 16'(exp[31:24]));
        compare("green_pwm high cycles", 16'(green_hi), 16'(exp[23:16]));
        compare("blue_pwm high cycles", 16'(blue_hi), 16'(exp[15:8]));
        compare("white_pwm high cycles", 16'(white_hi), 16'(exp[7:0]));
    endtask

    initial
    begin
        logic [55:0] e;
        logic [31:0] expected;
        clk = 1'b0;
        reset = 1'b0;
        mode = 8'h00;
        lint = 8'h00;
        color_idx = 8'h00;
        white_in = 8'h00;
        red_in = 8'h00;
        green_in = 8'h00;
        blue_in = 8'h00;
        errors = 0;
        timeouts = 0;
        seed = 59844;
        expected = 32'h0;

        repeat (4) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_levels(32'h0);
        compare("pwm pins", 16'({red_pwm, green_pwm, blue_pwm, white_pwm}), 16'h0);

        for (int i = 0; i < NUM_FIXED + NUM_RANDOM; i++)
        begin
            if (i < NUM_FIXED)
                e = STIM_TABLE[i];
            else
                e = random_entry();
            expected = expected_levels(e, expected);
            apply_entry(e);
            if (e[55:48] == DIRECT || e[55:48] == WHEEL)
                wait_for_levels(expected);
            else
                hold_levels(expected);
            check_levels(expected);
            measure_pwm(expected);
        end

        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
